//--- Makefile
SRCS := $(shell cat sources.f)
SIM  := obj_dir/Vtb_ooo_backend

.PHONY: all run clean

all: run

$(SIM): sources.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_ooo_backend -f sources.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST RESULT: PASS'

clean:
	rm -rf obj_dir

//--- common/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    // --------------------
    // Sizes
    localparam int XLEN      = 16;
    localparam int ARCH_REGS = 8;
    localparam int AREG_W    = 3;
    localparam int PHYS_REGS = 16;
    localparam int PREG_W    = 4;
    localparam int ROB_SIZE  = 8;
    localparam int ROB_W     = 3;
    localparam int RS_SIZE   = 4;
    localparam int RS_W      = 2;
    // Free list covers the pregs not mapped at reset
    localparam int FL_SIZE   = PHYS_REGS - ARCH_REGS;
    localparam int FL_W      = 3;
    localparam int IMM_W     = 8;
    // Multiply latency in cycles
    localparam int MUL_LAT   = 4;

    // --------------------
    // Instruction encoding
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_ADDI = 2'd2,
        OP_MUL  = 2'd3
    } op_e;

    // Register form
    typedef struct packed {
        op_e               op;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic [4:0]        spare;
    } inst_r_t;

    // Immediate form, imm is signed
    typedef struct packed {
        op_e               op;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [IMM_W-1:0]  imm;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    // --------------------
    // Inter-block structs
    typedef struct packed {
        logic              valid;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic              use_rs2;
    } ren_req_t;

    typedef struct packed {
        logic [PREG_W-1:0] new_preg;
        logic [PREG_W-1:0] old_preg;
        logic [PREG_W-1:0] src1;
        logic [PREG_W-1:0] src2;
        logic              rdy1;
        logic              rdy2;
    } ren_rsp_t;

    typedef struct packed {
        op_e               op;
        logic [PREG_W-1:0] dest;
        logic [PREG_W-1:0] src1;
        logic [PREG_W-1:0] src2;
        logic              rdy1;
        logic              rdy2;
        logic              use_rs2;
        logic [IMM_W-1:0]  imm;
        logic [ROB_W-1:0]  rob_idx;
    } rs_entry_t;

    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [PREG_W-1:0] dest;
        logic [ROB_W-1:0]  rob_idx;
        logic [XLEN-1:0]   opa;
        logic [XLEN-1:0]   opb;
        logic [IMM_W-1:0]  imm;
    } issue_t;

    typedef struct packed {
        logic              valid;
        logic [PREG_W-1:0] preg;
        logic [ROB_W-1:0]  rob_idx;
        logic [XLEN-1:0]   value;
    } cdb_t;

    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [AREG_W-1:0] rd;
        logic [PREG_W-1:0] new_preg;
        logic [PREG_W-1:0] old_preg;
        logic              done;
    } rob_entry_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [AREG_W-1:0] rd;
        logic [XLEN-1:0]   value;
    } retire_t;

endpackage

`default_nettype wire

//--- rtl/dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module dispatcher (
    input  logic                         in_valid_i,
    input  ooo_pkg::inst_u               inst_i,
    input  logic [ooo_pkg::XLEN-1:0]     pc_i,
    input  logic                         rs_full_i,
    input  logic                         rob_full_i,
    input  logic [ooo_pkg::ROB_W-1:0]    rob_tail_i,
    input  ooo_pkg::ren_rsp_t            ren_rsp_i,
    input  ooo_pkg::cdb_t                cdb_i,
    output logic                         in_ready_o,
    output ooo_pkg::ren_req_t            ren_req_o,
    output logic                         rs_wr_o,
    output ooo_pkg::rs_entry_t           rs_entry_o,
    output logic                         rob_wr_o,
    output ooo_pkg::rob_entry_t          rob_entry_o
);
    import ooo_pkg::*;

    op_e  op;
    logic is_imm;
    logic dispatch;

    // Opcode sits at the same bits in both views
    assign op     = inst_i.r.op;
    assign is_imm = (op == OP_ADDI);

    // Stall on either buffer full
    assign in_ready_o = !rs_full_i && !rob_full_i;
    assign dispatch   = in_valid_i && in_ready_o;

    // Rename request, ADDI has no second source
    assign ren_req_o = '{valid:   dispatch,
                         rd:      inst_i.r.rd,
                         rs1:     inst_i.r.rs1,
                         rs2:     inst_i.r.rs2,
                         use_rs2: !is_imm};

    always_comb begin
        rs_entry_o.op      = op;
        rs_entry_o.dest    = ren_rsp_i.new_preg;
        rs_entry_o.src1    = ren_rsp_i.src1;
        rs_entry_o.src2    = ren_rsp_i.src2;
        // Same-cycle CDB bypass, the ready bit is only set at the next edge
        rs_entry_o.rdy1    = ren_rsp_i.rdy1 ||
                             (cdb_i.valid && (cdb_i.preg == ren_rsp_i.src1));
        rs_entry_o.rdy2    = ren_rsp_i.rdy2 ||
                             (cdb_i.valid && (cdb_i.preg == ren_rsp_i.src2));
        rs_entry_o.use_rs2 = !is_imm;
        // Immediate view only for ADDI
        rs_entry_o.imm     = is_imm ? inst_i.i.imm : '0;
        // Tag by ROB slot about to be written
        rs_entry_o.rob_idx = rob_tail_i;
    end

    assign rob_entry_o = '{pc:       pc_i,
                           rd:       inst_i.r.rd,
                           new_preg: ren_rsp_i.new_preg,
                           old_preg: ren_rsp_i.old_preg,
                           done:     1'b0};

    // One strobe fans out to all three blocks
    assign rs_wr_o  = dispatch;
    assign rob_wr_o = dispatch;

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  ooo_pkg::issue_t  issue_i,
    output logic             busy_o,
    output ooo_pkg::cdb_t    cdb_o
);
    import ooo_pkg::*;

    // Operand latch, held through a multiply
    issue_t            ex_q;
    logic              ex_vld_q;
    // Remaining multiply cycles before broadcast
    logic [1:0]        mul_cnt_q;
    logic [XLEN-1:0]   result;
    logic [2*XLEN-1:0] product;

    logic              cdb_vld_q;
    logic [PREG_W-1:0] cdb_preg_q;
    logic [ROB_W-1:0]  cdb_rob_q;
    logic [XLEN-1:0]   cdb_val_q;

    // Busy until the last multiply cycle
    assign busy_o = ex_vld_q && (mul_cnt_q != '0);

    always_comb begin
        product = ex_q.opa * ex_q.opb;
        case (ex_q.op)
            OP_ADD:  result = ex_q.opa + ex_q.opb;
            OP_SUB:  result = ex_q.opa - ex_q.opb;
            // Sign-extended immediate
            OP_ADDI: result = ex_q.opa + {{(XLEN - IMM_W){ex_q.imm[IMM_W-1]}}, ex_q.imm};
            default: result = product[XLEN-1:0];
        endcase
    end

    // --------------------
    // Control
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_vld_q  <= 1'b0;
            mul_cnt_q <= '0;
            cdb_vld_q <= 1'b0;
        end else begin
            cdb_vld_q <= ex_vld_q && (mul_cnt_q == '0);
            if (issue_i.valid) begin
                ex_vld_q  <= 1'b1;
                mul_cnt_q <= (issue_i.op == OP_MUL) ? 2'(MUL_LAT - 1) : '0;
            end else if (mul_cnt_q != '0) begin
                mul_cnt_q <= mul_cnt_q - 1'b1;
            end else begin
                ex_vld_q <= 1'b0;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
        if (issue_i.valid) begin
            ex_q <= issue_i;
        end
        cdb_preg_q <= ex_q.dest;
        cdb_rob_q  <= ex_q.rob_idx;
        cdb_val_q  <= result;
    end

    assign cdb_o = '{valid: cdb_vld_q, preg: cdb_preg_q, rob_idx: cdb_rob_q, value: cdb_val_q};

endmodule

`default_nettype wire

//--- rtl/ooo_backend.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_backend (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      in_valid_i,
    input  ooo_pkg::inst_u            inst_i,
    input  logic [ooo_pkg::XLEN-1:0]  pc_i,
    output logic                      in_ready_o,
    output ooo_pkg::retire_t          retire_o
);
    import ooo_pkg::*;

    // --------------------
    // Dispatch side
    ren_req_t             ren_req;
    ren_rsp_t             ren_rsp;
    rs_entry_t            rs_entry;
    rob_entry_t           rob_entry;
    logic                 rs_wr;
    logic                 rob_wr;
    logic                 rs_full;
    logic                 rob_full;
    logic [ROB_W-1:0]     rob_tail;
    logic [PHYS_REGS-1:0] preg_ready;

    // Issue and completion
    issue_t               issue;
    cdb_t                 cdb;
    logic                 fu_busy;
    logic [PREG_W-1:0]    rd_addr1;
    logic [PREG_W-1:0]    rd_addr2;
    logic [XLEN-1:0]      rd_data1;
    logic [XLEN-1:0]      rd_data2;

    // Retire side
    rob_entry_t           rob_head;
    logic                 rob_retire;
    logic [XLEN-1:0]      rt_data;

    dispatcher u_dispatcher (
        .in_valid_i  (in_valid_i),
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .rs_full_i   (rs_full),
        .rob_full_i  (rob_full),
        .rob_tail_i  (rob_tail),
        .ren_rsp_i   (ren_rsp),
        .cdb_i       (cdb),
        .in_ready_o  (in_ready_o),
        .ren_req_o   (ren_req),
        .rs_wr_o     (rs_wr),
        .rs_entry_o  (rs_entry),
        .rob_wr_o    (rob_wr),
        .rob_entry_o (rob_entry)
    );

    // Released preg is the old mapping of the retiring entry
    rename_unit u_rename (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .ren_req_i   (ren_req),
        .src_ready_i (preg_ready),
        .free_wr_i   (rob_retire),
        .free_preg_i (rob_head.old_preg),
        .ren_rsp_o   (ren_rsp)
    );

    reorder_buffer u_rob (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rob_wr_i    (rob_wr),
        .rob_entry_i (rob_entry),
        .cdb_i       (cdb),
        .rob_full_o  (rob_full),
        .rob_tail_o  (rob_tail),
        .head_o      (rob_head),
        .retire_o    (rob_retire)
    );

    reservation_station u_rs (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs_wr_i    (rs_wr),
        .rs_entry_i (rs_entry),
        .cdb_i      (cdb),
        .fu_busy_i  (fu_busy),
        .rd_data1_i (rd_data1),
        .rd_data2_i (rd_data2),
        .rs_full_o  (rs_full),
        .rd_addr1_o (rd_addr1),
        .rd_addr2_o (rd_addr2),
        .issue_o    (issue)
    );

    exec_unit u_exec (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .issue_i  (issue),
        .busy_o   (fu_busy),
        .cdb_o    (cdb)
    );

    // Dispatch strobe clears the new destination's ready bit
    phys_regfile u_prf (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .clr_ready_i (rs_wr),
        .clr_preg_i  (ren_rsp.new_preg),
        .cdb_i       (cdb),
        .rd_addr1_i  (rd_addr1),
        .rd_addr2_i  (rd_addr2),
        .rt_addr_i   (rob_head.new_preg),
        .rd_data1_o  (rd_data1),
        .rd_data2_o  (rd_data2),
        .rt_data_o   (rt_data),
        .ready_o     (preg_ready)
    );

    // Retire record from ROB head and PRF retire port
    assign retire_o = '{valid: rob_retire, pc: rob_head.pc, rd: rob_head.rd, value: rt_data};

endmodule

`default_nettype wire

//--- rtl/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           clr_ready_i,
    input  logic [ooo_pkg::PREG_W-1:0]     clr_preg_i,
    input  ooo_pkg::cdb_t                  cdb_i,
    input  logic [ooo_pkg::PREG_W-1:0]     rd_addr1_i,
    input  logic [ooo_pkg::PREG_W-1:0]     rd_addr2_i,
    input  logic [ooo_pkg::PREG_W-1:0]     rt_addr_i,
    output logic [ooo_pkg::XLEN-1:0]       rd_data1_o,
    output logic [ooo_pkg::XLEN-1:0]       rd_data2_o,
    output logic [ooo_pkg::XLEN-1:0]       rt_data_o,
    output logic [ooo_pkg::PHYS_REGS-1:0]  ready_o
);
    import ooo_pkg::*;

    logic [XLEN-1:0]      val_q [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready_q;

    // Two issue ports and the retire port, all combinational
    assign rd_data1_o = val_q[rd_addr1_i];
    assign rd_data2_o = val_q[rd_addr2_i];
    assign rt_data_o  = val_q[rt_addr_i];
    assign ready_o    = ready_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // All zero and ready
            for (int i = 0; i < PHYS_REGS; i++) begin
                val_q[i] <= '0;
            end
            ready_q <= '1;
        end else begin
            // New destination pending until its broadcast
            if (clr_ready_i) begin
                ready_q[clr_preg_i] <= 1'b0;
            end
            if (cdb_i.valid) begin
                val_q[cdb_i.preg]   <= cdb_i.value;
                ready_q[cdb_i.preg] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/rename_unit.sv
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  ooo_pkg::ren_req_t              ren_req_i,
    input  logic [ooo_pkg::PHYS_REGS-1:0]  src_ready_i,
    input  logic                           free_wr_i,
    input  logic [ooo_pkg::PREG_W-1:0]     free_preg_i,
    output ooo_pkg::ren_rsp_t              ren_rsp_o
);
    import ooo_pkg::*;

    // Map table, arch reg to current preg
    logic [PREG_W-1:0] map_q [ARCH_REGS];
    // Circular free list, never runs dry with 8 ROB entries
    logic [PREG_W-1:0] fl_q  [FL_SIZE];
    logic [FL_W-1:0]   fl_head_q;
    logic [FL_W-1:0]   fl_tail_q;

    // --------------------
    // Lookup
    always_comb begin
        ren_rsp_o.new_preg = fl_q[fl_head_q];
        ren_rsp_o.old_preg = map_q[ren_req_i.rd];
        ren_rsp_o.src1     = map_q[ren_req_i.rs1];
        ren_rsp_o.src2     = map_q[ren_req_i.rs2];
        ren_rsp_o.rdy1     = src_ready_i[map_q[ren_req_i.rs1]];
        // Unused second source counts as ready
        ren_rsp_o.rdy2     = !ren_req_i.use_rs2 || src_ready_i[map_q[ren_req_i.rs2]];
    end

    // --------------------
    // Update
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Identity map, upper half free
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= PREG_W'(i);
            end
            for (int i = 0; i < FL_SIZE; i++) begin
                fl_q[i] <= PREG_W'(i + ARCH_REGS);
            end
            fl_head_q <= '0;
            fl_tail_q <= '0;
        end else begin
            // Pop on dispatch
            if (ren_req_i.valid) begin
                map_q[ren_req_i.rd] <= fl_q[fl_head_q];
                fl_head_q           <= fl_head_q + 1'b1;
            end
            // Push old mapping on retire
            if (free_wr_i) begin
                fl_q[fl_tail_q] <= free_preg_i;
                fl_tail_q       <= fl_tail_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       rob_wr_i,
    input  ooo_pkg::rob_entry_t        rob_entry_i,
    input  ooo_pkg::cdb_t              cdb_i,
    output logic                       rob_full_o,
    output logic [ooo_pkg::ROB_W-1:0]  rob_tail_o,
    output ooo_pkg::rob_entry_t        head_o,
    output logic                       retire_o
);
    import ooo_pkg::*;

    rob_entry_t       rob_q [ROB_SIZE];
    logic [ROB_W-1:0] head_q;
    logic [ROB_W-1:0] tail_q;
    // One extra bit to tell full from empty
    logic [ROB_W:0]   count_q;

    assign rob_full_o = (count_q == (ROB_W + 1)'(ROB_SIZE));
    assign rob_tail_o = tail_q;
    assign head_o     = rob_q[head_q];
    // Retire head once its result is on the PRF
    assign retire_o   = (count_q != '0) && rob_q[head_q].done;

    // --------------------
    // Entry storage
    always_ff @(posedge clk_i) begin
        if (rob_wr_i) begin
            rob_q[tail_q] <= rob_entry_i;
        end
        // Completion by ROB index
        if (cdb_i.valid) begin
            rob_q[cdb_i.rob_idx].done <= 1'b1;
        end
    end

    // --------------------
    // Pointers
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (rob_wr_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_o) begin
                head_q <= head_q + 1'b1;
            end
            // Net occupancy change
            case ({rob_wr_i, retire_o})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        rs_wr_i,
    input  ooo_pkg::rs_entry_t          rs_entry_i,
    input  ooo_pkg::cdb_t               cdb_i,
    input  logic                        fu_busy_i,
    input  logic [ooo_pkg::XLEN-1:0]    rd_data1_i,
    input  logic [ooo_pkg::XLEN-1:0]    rd_data2_i,
    output logic                        rs_full_o,
    output logic [ooo_pkg::PREG_W-1:0]  rd_addr1_o,
    output logic [ooo_pkg::PREG_W-1:0]  rd_addr2_o,
    output ooo_pkg::issue_t             issue_o
);
    import ooo_pkg::*;

    rs_entry_t          rs_q [RS_SIZE];
    logic [RS_SIZE-1:0] valid_q;
    // older_q[i][j] set when entry i was written before entry j
    logic [RS_SIZE-1:0] older_q [RS_SIZE];

    logic [RS_SIZE-1:0] ready;
    logic [RS_SIZE-1:0] oldest;
    logic [RS_W-1:0]    sel;
    logic               any_ready;
    logic [RS_W-1:0]    wr_slot;

    assign rs_full_o = &valid_q;

    // --------------------
    // Issue select
    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            ready[i] = valid_q[i] && rs_q[i].rdy1 && (rs_q[i].rdy2 || !rs_q[i].use_rs2);
        end
        // Ready and no older ready entry
        for (int i = 0; i < RS_SIZE; i++) begin
            oldest[i] = ready[i];
            for (int j = 0; j < RS_SIZE; j++) begin
                if (ready[j] && older_q[j][i]) begin
                    oldest[i] = 1'b0;
                end
            end
        end
        sel       = '0;
        any_ready = 1'b0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (oldest[i]) begin
                sel       = RS_W'(i);
                any_ready = 1'b1;
            end
        end
    end

    // Operand fetch for the selected entry
    assign rd_addr1_o = rs_q[sel].src1;
    assign rd_addr2_o = rs_q[sel].src2;

    assign issue_o = '{valid:   any_ready && !fu_busy_i,
                       op:      rs_q[sel].op,
                       dest:    rs_q[sel].dest,
                       rob_idx: rs_q[sel].rob_idx,
                       opa:     rd_data1_i,
                       opb:     rd_data2_i,
                       imm:     rs_q[sel].imm};

    // Lowest free slot for dispatch
    always_comb begin
        wr_slot = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                wr_slot = RS_W'(i);
            end
        end
    end

    // --------------------
    // Payload and wakeup
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (cdb_i.valid && (rs_q[i].src1 == cdb_i.preg)) begin
                rs_q[i].rdy1 <= 1'b1;
            end
            if (cdb_i.valid && (rs_q[i].src2 == cdb_i.preg)) begin
                rs_q[i].rdy2 <= 1'b1;
            end
        end
        // Payload already carries the bypassed ready bits
        if (rs_wr_i) begin
            rs_q[wr_slot] <= rs_entry_i;
        end
    end

    // --------------------
    // Valid bits and age
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < RS_SIZE; i++) begin
                older_q[i] <= '0;
            end
        end else begin
            if (issue_o.valid) begin
                valid_q[sel] <= 1'b0;
            end
            if (rs_wr_i) begin
                valid_q[wr_slot] <= 1'b1;
                // Everything present is older than the new entry
                older_q[wr_slot] <= '0;
                for (int j = 0; j < RS_SIZE; j++) begin
                    older_q[j][wr_slot] <= valid_q[j];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sources.f
common/ooo_pkg.sv
rtl/dispatcher.sv
rtl/rename_unit.sv
rtl/reorder_buffer.sv
rtl/reservation_station.sv
rtl/exec_unit.sv
rtl/phys_regfile.sv
rtl/ooo_backend.sv
tests/tb_ooo_backend.sv

//--- tests/tb_ooo_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_backend;
    import ooo_pkg::*;

    // About 120 instructions at a MUL-bound rate with fourfold margin
    localparam int NUM_INSTS  = 120;
    localparam int MAX_CYCLES = NUM_INSTS * (MUL_LAT + 2) * 4 + 120;

    // Expected retire record
    typedef struct packed {
        logic [XLEN-1:0]   pc;
        logic [AREG_W-1:0] rd;
        logic [XLEN-1:0]   value;
    } exp_t;

    logic            clk_i;
    logic            arst_n_i;
    logic            in_valid_i;
    inst_u           inst_i;
    logic [XLEN-1:0] pc_i;
    logic            in_ready_o;
    retire_t         retire_o;

    // --------------------
    // Reference model state
    exp_t            exp_q [$];
    exp_t            exp_head;
    logic            exp_any;
    logic [XLEN-1:0] arch_q [ARCH_REGS];
    logic [XLEN-1:0] next_pc;

    int   seed;
    int   errors;
    int   dispatched;
    int   retired;
    int   cycles;
    int   test_start_errs;
    int   test_start_insts;
    // Gates the post-reset idle checks
    logic idle_chk;
    logic saw_stall;

    ooo_backend dut (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_valid_i (in_valid_i),
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .in_ready_o (in_ready_o),
        .retire_o   (retire_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    // --------------------
    // Instruction builders
    function automatic inst_u reg_form(input op_e op, input logic [AREG_W-1:0] rd,
                                       input logic [AREG_W-1:0] rs1,
                                       input logic [AREG_W-1:0] rs2);
        inst_u u;
        u.r = '{op: op, rd: rd, rs1: rs1, rs2: rs2, spare: 5'd0};
        return u;
    endfunction

    function automatic inst_u imm_form(input logic [AREG_W-1:0] rd,
                                       input logic [AREG_W-1:0] rs1,
                                       input logic [IMM_W-1:0] imm);
        inst_u u;
        u.i = '{op: OP_ADDI, rd: rd, rs1: rs1, imm: imm};
        return u;
    endfunction

    // Architectural result from the current register values
    function automatic logic [XLEN-1:0] model_result(input inst_u inst);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_ext;
        logic [XLEN-1:0] res;
        a       = arch_q[inst.r.rs1];
        b       = arch_q[inst.r.rs2];
        imm_ext = XLEN'($signed(inst.i.imm));
        case (inst.r.op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_ADDI: res = a + imm_ext;
            // Low half of the product
            default: res = a * b;
        endcase
        return res;
    endfunction

    // Front of the expected queue as plain variables
    function automatic void refresh_head();
        exp_any = (exp_q.size() != 0);
        if (exp_any) begin
            exp_head = exp_q[0];
        end else begin
            exp_head = '0;
        end
    endfunction

    // --------------------
    // Stimulus tasks
    task automatic send(input inst_u inst);
        exp_t rec;
        rec.pc     = next_pc;
        rec.rd     = inst.r.rd;
        rec.value  = model_result(inst);
        in_valid_i <= 1'b1;
        inst_i     <= inst;
        pc_i       <= next_pc;
        // Hold until sampled with in_ready_o high
        do begin
            @(posedge clk_i);
            if (!in_ready_o) begin
                saw_stall = 1'b1;
            end
        end while (!in_ready_o);
        // Model update in program order once accepted
        arch_q[inst.r.rd] = rec.value;
        exp_q.push_back(rec);
        refresh_head();
        dispatched++;
        next_pc = next_pc + 16'd2;
    endtask

    // Wait for every expected retire
    task automatic drain();
        in_valid_i <= 1'b0;
        do begin
            @(negedge clk_i);
        end while (exp_q.size() != 0);
        @(posedge clk_i);
    endtask

    task automatic report(input string name);
        int n_err;
        n_err = errors - test_start_errs;
        $display("%s: %0d instructions, %0d errors, %s", name,
                 dispatched - test_start_insts, n_err, (n_err == 0) ? "ok" : "failed");
        test_start_errs  = errors;
        test_start_insts = dispatched;
    endtask

    // --------------------
    // Retire monitor pops at the edge after the check
    always @(posedge clk_i) begin
        if (arst_n_i && retire_o.valid) begin
            retired++;
            if (exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            refresh_head();
        end
    end

    // Run limit
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, instructions still waiting to retire", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // --------------------
    // Retire checks sampled mid-cycle
    a_expected: assert property (@(negedge clk_i) disable iff (!arst_n_i)
            retire_o.valid |-> exp_any)
        else begin
            $display("Retire at pc %h with no instruction left in the model", retire_o.pc);
            errors++;
        end

    a_pc: assert property (@(negedge clk_i) disable iff (!arst_n_i)
            retire_o.valid && exp_any |-> retire_o.pc == exp_head.pc)
        else begin
            $display("[FAIL] retire_o.pc got %h expected %h", retire_o.pc, exp_head.pc);
            errors++;
        end

    a_rd: assert property (@(negedge clk_i) disable iff (!arst_n_i)
            retire_o.valid && exp_any |-> retire_o.rd == exp_head.rd)
        else begin
            $display("[FAIL] retire_o.rd got %h expected %h", retire_o.rd, exp_head.rd);
            errors++;
        end

    a_value: assert property (@(negedge clk_i) disable iff (!arst_n_i)
            retire_o.valid && exp_any |-> retire_o.value == exp_head.value)
        else begin
            $display("[FAIL] retire_o.value got %h expected %h at pc %h",
                     retire_o.value, exp_head.value, retire_o.pc);
            errors++;
        end

    // Idle after reset
    a_idle_ready: assert property (@(negedge clk_i) disable iff (!arst_n_i)
            idle_chk |-> in_ready_o)
        else begin
            $display("[FAIL] in_ready_o got %h expected %h", in_ready_o, 1'b1);
            errors++;
        end

    a_idle_retire: assert property (@(negedge clk_i) disable iff (!arst_n_i)
            idle_chk |-> !retire_o.valid)
        else begin
            $display("[FAIL] retire_o.valid got %h expected %h", retire_o.valid, 1'b0);
            errors++;
        end

    // --------------------
    // Test sequence
    initial begin
        logic [AREG_W-1:0] rd;
        logic [31:0]       r;
        seed             = 15;
        errors           = 0;
        dispatched       = 0;
        retired          = 0;
        cycles           = 0;
        test_start_errs  = 0;
        test_start_insts = 0;
        idle_chk         = 1'b0;
        saw_stall        = 1'b0;
        next_pc          = 16'h0100;
        exp_any          = 1'b0;
        exp_head         = '0;
        arst_n_i         = 1'b0;
        in_valid_i       = 1'b0;
        inst_i           = '0;
        pc_i             = '0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            arch_q[i] = '0;
        end
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // Nothing presented
        idle_chk <= 1'b1;
        repeat (10) @(posedge clk_i);
        idle_chk <= 1'b0;
        report("reset_idle");

        // Independent ADDI for each register
        for (int i = 0; i < ARCH_REGS; i++) begin
            send(imm_form(AREG_W'(i), AREG_W'(i), IMM_W'(i * 37 - 100)));
        end
        drain();
        report("addi_run");

        // Dependent chain
        // Filler ADDI puts the third instruction on the broadcast cycle of the first
        send(reg_form(OP_ADD, 3'd1, 3'd1, 3'd2));
        send(reg_form(OP_SUB, 3'd3, 3'd1, 3'd0));
        send(imm_form(3'd6, 3'd6, 8'd9));
        send(reg_form(OP_ADD, 3'd1, 3'd3, 3'd1));
        send(imm_form(3'd7, 3'd7, 8'hf3));
        send(reg_form(OP_SUB, 3'd2, 3'd1, 3'd2));
        send(reg_form(OP_ADD, 3'd4, 3'd2, 3'd2));
        send(reg_form(OP_SUB, 3'd4, 3'd4, 3'd1));
        send(reg_form(OP_ADD, 3'd0, 3'd4, 3'd3));
        send(reg_form(OP_SUB, 3'd5, 3'd0, 3'd0));
        drain();
        report("dep_chain");

        // Few destinations with enough writes to wrap the free list
        for (int i = 0; i < 20; i++) begin
            rd = AREG_W'(5 + i % 3);
            if (i % 4 == 3) begin
                send(imm_form(rd, rd, IMM_W'(i)));
            end else begin
                send(reg_form((i % 2 == 1) ? OP_SUB : OP_ADD, rd,
                              AREG_W'(5 + (i + 1) % 3), rd));
            end
        end
        drain();
        report("preg_recycle");

        // Dependent MUL stream fills the RS behind the busy multiplier
        saw_stall = 1'b0;
        send(imm_form(3'd1, 3'd0, 8'd3));
        send(imm_form(3'd2, 3'd0, 8'd5));
        for (int i = 0; i < 10; i++) begin
            send(reg_form(OP_MUL, AREG_W'(1 + i % 2), 3'd1, 3'd2));
        end
        drain();
        assert (saw_stall) else begin
            $display("in_ready_o never went low during the MUL stream");
            errors++;
        end
        report("mul_stall");

        // Random mix
        for (int i = 0; i < 60; i++) begin
            r = $random(seed);
            if (op_e'(r[1:0]) == OP_ADDI) begin
                send(imm_form(r[4:2], r[7:5], r[18:11]));
            end else begin
                send(reg_form(op_e'(r[1:0]), r[4:2], r[7:5], r[10:8]));
            end
        end
        drain();
        assert (retired == dispatched) else begin
            $display("[FAIL] retired got %h expected %h", retired, dispatched);
            errors++;
        end
        report("random_mix");

        $display("Totals: %0d dispatched, %0d retired, %0d errors",
                 dispatched, retired, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
